/* Makefile */
# Verilator build for the Wishbone interconnect testbench

SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := wb_ic_tb
FILELIST := wb_ic.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := Simulation passed

SOURCES  := $(shell grep -v '^+' $(FILELIST))
EXE      := $(BUILD)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

# The log decides the result, the exit status follows it
run: compile
	./$(EXE) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "No pass line found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

/* sim/wb_ic_tb.sv */
`timescale 1ns/1ps

// Testbench for the one-master, four-slave Wishbone interconnect
// Master side driven from here against behavioral slave models
module wb_ic_tb import wb_ic_pkg::*; ();

	localparam int RESET_CYCLES = 8;
	localparam int RANDOM_XFERS = 150;
	// About 200 transfers of up to 9 cycles plus reset and margin
	localparam int MAX_CYCLES   = 3000;
	// Ack latency of each behavioral slave
	localparam int SLAVE_LAT [N_SLAVES] = '{1, 2, 3, 6};

	logic    clk;
	logic    rstn;
	wb_req_t m_req;
	wb_rsp_t m_rsp;
	wb_req_t s_req [N_SLAVES];
	wb_rsp_t s_rsp [N_SLAVES];

	// Expected contents of every slave memory
	logic [31:0] shadow [N_SLAVES][64];
	logic [31:0] rng_state = 32'd56070;

	int   cyc_cnt    = 0;
	int   value_errs = 0;
	int   bus_errs   = 0;
	int   xfer_cnt   = 0;
	// Transfer in flight and the target the map rule picks for it
	logic xfer_act;
	int   exp_tgt;

	wb_ic_tb_clkgen u_clkgen (
		.clk_o (clk)
	);

	wb_ic_top dut0 (
		.clk     (clk),
		.rstn    (rstn),
		.m_req_i (m_req),
		.m_rsp_o (m_rsp),
		.s_req_o (s_req),
		.s_rsp_i (s_rsp)
	);

	for (genvar i = 0; i < N_SLAVES; i++) begin : g_slave
		wb_ic_tb_slave #(
			.ACK_LAT   (SLAVE_LAT[i]),
			.SLAVE_IDX (i)
		) u_slave (
			.clk   (clk),
			.rstn  (rstn),
			.req_i (s_req[i]),
			.rsp_o (s_rsp[i])
		);
	end

	always @(posedge clk) begin
		cyc_cnt <= cyc_cnt + 1;
	end

	task automatic flag_value_error(input string msg);
		$display("CHECK FAILED at %0t: %s", $time, msg);
		value_errs++;
	endtask

	task automatic flag_bus_error(input string msg);
		$display("CHECK FAILED at %0t: %s", $time, msg);
		bus_errs++;
	endtask

	// Bus-level rules sampled at the rising edge
	assert property (@(posedge clk) !(m_rsp.ack && m_rsp.err))
		else flag_bus_error("ack and err high together");

	assert property (@(posedge clk) (cyc_cnt >= 1 && !xfer_act) |-> !(m_rsp.ack || m_rsp.err))
		else flag_bus_error("reply to the master with no transfer");

	// A slave only sees a request when the map rule picks it
	for (genvar i = 0; i < N_SLAVES; i++) begin : g_stray
		assert property (@(posedge clk)
			(cyc_cnt >= 1 && (s_req[i].cyc || s_req[i].stb)) |-> (xfer_act && exp_tgt == i))
			else flag_bus_error($sformatf("slave %0d selected without a matching transfer", i));
	end

	// xorshift32
	function automatic logic [31:0] next_rand();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	// Address map rule with the lowest window first
	function automatic int ref_target(input logic [31:0] addr);
		if (addr <= 32'h0000_0FFF) return 0;
		if (addr >= 32'h0000_1000 && addr <= 32'h0000_1FFF) return 1;
		if (addr >= 32'h1000_0000 && addr <= 32'h1000_FFFF) return 2;
		if (addr >= 32'h2000_0000 && addr <= 32'h2FFF_FFFF) return 3;
		return int'(ERR_TARGET);
	endfunction

	function automatic logic [31:0] fill_word(input int s, input int k);
		return 32'hC0DE_0000 | (32'(s) << 8) | 32'(k);
	endfunction

	// Mostly in-window addresses with a third drawn from the whole space
	function automatic logic [31:0] rand_addr();
		logic [31:0] r;
		logic [31:0] pick;
		r    = next_rand();
		pick = next_rand();
		case (pick % 6)
			0: return r & 32'h0000_0FFC;
			1: return 32'h0000_1000 | (r & 32'h0000_0FFC);
			2: return 32'h1000_0000 | (r & 32'h0000_FFFC);
			3: return 32'h2000_0000 | (r & 32'h0FFF_FFFC);
			default: return r & 32'hFFFF_FFFC;
		endcase
	endfunction

	task automatic check_idle();
		assert (!m_rsp.ack && !m_rsp.err) else flag_value_error("reply active while idle");
		for (int i = 0; i < N_SLAVES; i++) begin
			assert (!s_req[i].cyc && !s_req[i].stb)
				else flag_value_error($sformatf("slave %0d sees cyc or stb while idle", i));
		end
	endtask

	// Picked slave carries the master request while all others stay zero
	task automatic check_routing(input int tgt);
		for (int i = 0; i < N_SLAVES; i++) begin
			if (i == tgt) begin
				assert (s_req[i] == m_req)
					else flag_value_error($sformatf("slave %0d request differs from master", i));
			end else begin
				assert (s_req[i] == '0)
					else flag_value_error($sformatf("slave %0d request not zero", i));
			end
		end
	endtask

	// One transfer driven on falling edges and checked against the map rule
	task automatic bus_xfer(input logic [31:0] addr, input logic we, input logic [31:0] wdata);
		int          tgt;
		int          n;
		logic [31:0] exp_rd;
		logic [31:0] side;
		wb_rsp_t     rsp;
		tgt    = ref_target(addr);
		side   = next_rand();
		exp_rd = '0;
		if (tgt < N_SLAVES) begin
			exp_rd = shadow[tgt][addr[7:2]];
		end
		m_req.adr   = addr;
		m_req.dat_w = wdata;
		// Select and burst tags vary so their pass-through is covered
		m_req.sel   = side[3:0];
		m_req.we    = we;
		m_req.cyc   = 1'b1;
		m_req.stb   = 1'b1;
		m_req.cti   = side[6:4];
		m_req.bte   = side[8:7];
		exp_tgt     = tgt;
		xfer_act    = 1'b1;
		n   = 0;
		rsp = '0;
		// Request held until ack or err shows up
		while (!(rsp.ack || rsp.err)) begin
			@(negedge clk);
			n++;
			check_routing(tgt);
			rsp = m_rsp;
		end
		if (tgt == int'(ERR_TARGET)) begin
			// err sampled at edge T+2
			assert (rsp.err && !rsp.ack && rsp.dat_r == '0 && n == 2)
				else flag_value_error($sformatf("decode-fail %08h: err %0b ack %0b dat %08h, %0d cyc",
					addr, rsp.err, rsp.ack, rsp.dat_r, n));
		end else begin
			assert (rsp.ack && !rsp.err && n == SLAVE_LAT[tgt] + 1)
				else flag_value_error($sformatf("slave %0d at %08h: ack %0b err %0b after %0d cyc",
					tgt, addr, rsp.ack, rsp.err, n));
			if (!we) begin
				assert (rsp.dat_r == exp_rd)
					else flag_value_error($sformatf("read %08h got %08h expected %08h",
						addr, rsp.dat_r, exp_rd));
			end else begin
				shadow[tgt][addr[7:2]] = wdata;
			end
		end
		// Master lets go one edge after it saw the reply
		@(negedge clk);
		assert (!m_rsp.ack && !m_rsp.err) else flag_value_error("reply longer than one cycle");
		m_req    = '0;
		xfer_act = 1'b0;
		xfer_cnt++;
	endtask

	initial begin : watchdog
		while (cyc_cnt < MAX_CYCLES) begin
			@(posedge clk);
		end
		$display("Run timed out after %0d cycles without finishing the tests", cyc_cnt);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		logic [31:0] addr;
		logic [31:0] rnd;
		rstn     = 1'b0;
		// Request held through reset must not reach any slave
		m_req     = '0;
		m_req.adr = 32'h0000_1000;
		m_req.cyc = 1'b1;
		m_req.stb = 1'b1;
		xfer_act = 1'b0;
		exp_tgt  = 0;
		for (int s = 0; s < N_SLAVES; s++) begin
			for (int k = 0; k < 64; k++) begin
				shadow[s][k] = fill_word(s, k);
			end
		end

		// Bus stays quiet throughout reset
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			check_idle();
		end
		rstn  = 1'b1;
		m_req = '0;
		@(negedge clk);
		check_idle();

		// Write then read in each window including window edges
		bus_xfer(32'h0000_0010, 1'b1, next_rand());
		bus_xfer(32'h0000_0010, 1'b0, '0);
		bus_xfer(32'h0000_1FFC, 1'b1, next_rand());
		bus_xfer(32'h0000_1FFC, 1'b0, '0);
		bus_xfer(32'h1000_FF00, 1'b1, next_rand());
		bus_xfer(32'h1000_FF00, 1'b0, '0);
		bus_xfer(32'h2FFF_FFFC, 1'b1, next_rand());
		bus_xfer(32'h2FFF_FFFC, 1'b0, '0);

		// Unmapped addresses
		bus_xfer(32'h4000_0000, 1'b0, '0);
		bus_xfer(32'h0000_2000, 1'b1, next_rand());
		bus_xfer(32'h1001_0000, 1'b0, '0);

		// Slow slave 3 followed by a hop to slave 1
		bus_xfer(32'h2000_0100, 1'b1, next_rand());
		bus_xfer(32'h2000_0100, 1'b0, '0);
		bus_xfer(32'h0000_1040, 1'b0, '0);

		// Random mix of reads and writes
		repeat (RANDOM_XFERS) begin
			addr = rand_addr();
			rnd  = next_rand();
			bus_xfer(addr, rnd[0], next_rand());
		end

		@(negedge clk);
		$display("Summary: %0d transfers, %0d value errors, %0d bus errors",
			xfer_cnt, value_errs, bus_errs);
		if (value_errs + bus_errs == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* sim/wb_ic_tb_clkgen.sv */
`timescale 1ns/1ps

// Free-running testbench clock
// 20 ns period, starts low
module wb_ic_tb_clkgen (
	output logic clk_o
);

	// Half of the 20 ns period
	localparam int HALF_PERIOD = 10;

	initial begin
		clk_o = 1'b0;
		forever begin
			#HALF_PERIOD;
			clk_o = ~clk_o;
		end
	end

endmodule

/* sim/wb_ic_tb_slave.sv */
`timescale 1ns/1ps

// Behavioral Wishbone memory slave
// Acks ACK_LAT cycles after it first sees stb, one word per transfer
// 64 words, indexed by address bits [7:2]
module wb_ic_tb_slave import wb_ic_pkg::*; #(
	parameter int ACK_LAT   = 1,
	parameter int SLAVE_IDX = 0
) (
	input  logic    clk,
	input  logic    rstn,
	input  wb_req_t req_i,
	output wb_rsp_t rsp_o
);

	logic [WB_DATA_WIDTH-1:0] mem [64];
	logic [WB_DATA_WIDTH-1:0] dat_q = '0;
	logic                     ack_q = 1'b0;
	// Edges spent on the current request so far
	int                       wait_cnt = 0;
	logic [5:0]               idx;

	assign idx = req_i.adr[7:2];

	// Start-up contents, one distinct word per slave and index
	initial begin
		for (int k = 0; k < 64; k++) begin
			mem[k] = 32'hC0DE_0000 | (32'(SLAVE_IDX) << 8) | 32'(k);
		end
	end

	always @(posedge clk) begin
		if (!rstn) begin
			ack_q    <= 1'b0;
			dat_q    <= '0;
			wait_cnt <= 0;
		end else if (ack_q) begin
			// Ack is a single-cycle pulse
			ack_q <= 1'b0;
		end else if (req_i.cyc && req_i.stb) begin
			if (wait_cnt == ACK_LAT - 1) begin
				ack_q    <= 1'b1;
				wait_cnt <= 0;
				// Write lands together with the ack
				if (req_i.we) begin
					mem[idx] <= req_i.dat_w;
					dat_q    <= '0;
				end else begin
					dat_q <= mem[idx];
				end
			end else begin
				wait_cnt <= wait_cnt + 1;
			end
		end
	end

	assign rsp_o.dat_r = dat_q;
	assign rsp_o.ack   = ack_q;
	// Mapped slaves never signal err
	assign rsp_o.err   = 1'b0;

endmodule

/* verilog/wb_ic_addr_decode.sv */
`timescale 1ns/1ps

// Address decode and request fan-out
// Two states: idle (busy_q low) and busy (busy_q high)
// The target is latched on the first cyc/stb seen while idle and
// held until the selected target ends the transfer
module wb_ic_addr_decode import wb_ic_pkg::*; (
	input  logic      clk,
	input  logic      rstn,

	// Request from the master
	input  wb_req_t   m_req_i,

	// Selected reply carries ack or err
	input  logic      done_i,

	// Per-target requests
	output wb_req_t   tgt_req_o [N_SLAVES],
	output wb_req_t   err_req_o,

	// Latched target for the response path
	output slave_id_t sel_id_o,
	output logic      busy_o
);

	// Window compare result for the current address
	slave_id_t hit_id;

	// Latch state
	logic      busy_q;
	slave_id_t sel_q;

	// Map an address onto a target id
	function automatic slave_id_t addr_to_target(
		input logic [WB_ADDR_WIDTH-1:0] addr
	);
		slave_id_t id;
		// Falls through to the error target when nothing matches
		id = ERR_TARGET;
		// Walk downwards so the lowest matching window is the last to set id
		for (int i = N_SLAVES - 1; i >= 0; i--) begin
			if (addr >= SLAVE_BASE[i] && addr <= SLAVE_LIMIT[i]) begin
				id = slave_id_t'(i);
			end
		end
		return id;
	endfunction

	// Combinational window compare
	always_comb begin
		hit_id = addr_to_target(m_req_i.adr);
	end

	// Target latch
	always_ff @(posedge clk) begin
		if (!rstn) begin
			busy_q <= 1'b0;
			sel_q  <= '0;
		end else begin
			if (!busy_q) begin
				// New transfer starts on cyc and stb together
				if (m_req_i.cyc && m_req_i.stb) begin
					busy_q <= 1'b1;
					sel_q  <= hit_id;
				end
			end else begin
				// ack or err from the chosen target ends it
				if (done_i) begin
					busy_q <= 1'b0;
				end
			end
		end
	end

	// Request steering
	// Everything not selected sees an all-zero request, including
	// cyc and stb, so idle slaves stay quiet
	always_comb begin
		for (int i = 0; i < N_SLAVES; i++) begin
			tgt_req_o[i] = '0;
		end
		err_req_o = '0;

		if (busy_q) begin
			if (sel_q == ERR_TARGET) begin
				err_req_o = m_req_i;
			end else begin
				for (int i = 0; i < N_SLAVES; i++) begin
					if (sel_q == slave_id_t'(i)) begin
						tgt_req_o[i] = m_req_i;
					end
				end
			end
		end
	end

	// Latch state out to the response mux
	assign sel_id_o = sel_q;
	assign busy_o   = busy_q;

endmodule

/* verilog/wb_ic_decode_err.sv */
`timescale 1ns/1ps

// Decode-fail target
// Answers any access that hit no window with a single err pulse,
// one cycle after stb first shows up
module wb_ic_decode_err import wb_ic_pkg::*; (
	input  logic    clk,
	input  logic    rstn,

	// Request routed here by the decoder
	input  wb_req_t err_req_i,

	// Reply, never ack and always zero data
	output wb_rsp_t err_rsp_o
);

	// Registered err pulse
	logic err_q;

	// Set once the pulse for the current request has been issued
	logic armed_q;

	// Request is active on this cycle
	logic req_act;

	assign req_act = err_req_i.cyc && err_req_i.stb;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_q   <= 1'b0;
			armed_q <= 1'b0;
		end else begin
			// Pulse lasts one cycle by default
			err_q <= 1'b0;

			if (req_act) begin
				if (!armed_q) begin
					err_q   <= 1'b1;
					armed_q <= 1'b1;
				end
			end else begin
				// Request gone, ready for the next one
				armed_q <= 1'b0;
			end
		end
	end

	// Drive the reply fields
	always_comb begin
		err_rsp_o       = '0;
		err_rsp_o.dat_r = '0;
		err_rsp_o.ack   = 1'b0;
		err_rsp_o.err   = err_q;
	end

endmodule

/* verilog/wb_ic_pkg.sv */
package wb_ic_pkg;

	// Bus widths
	localparam int WB_ADDR_WIDTH = 32;
	localparam int WB_DATA_WIDTH = 32;
	// One select bit per data byte
	localparam int WB_SEL_WIDTH = WB_DATA_WIDTH / 8;

	// Real slaves behind the interconnect
	localparam int N_SLAVES = 4;
	// Ids 0..3 are slaves, id 4 is the decode-fail target
	localparam int SLAVE_ID_W = 3;

	typedef logic [SLAVE_ID_W-1:0] slave_id_t;

	// Target that terminates unmapped accesses
	localparam slave_id_t ERR_TARGET = 3'd4;

	// Address windows, both bounds inclusive
	// Lowest-numbered matching window wins
	localparam logic [WB_ADDR_WIDTH-1:0] SLAVE_BASE [N_SLAVES] = '{
		32'h0000_0000,
		32'h0000_1000,
		32'h1000_0000,
		32'h2000_0000
	};

	localparam logic [WB_ADDR_WIDTH-1:0] SLAVE_LIMIT [N_SLAVES] = '{
		32'h0000_0FFF,
		32'h0000_1FFF,
		32'h1000_FFFF,
		32'h2FFF_FFFF
	};

	// Master to slave signals
	typedef struct packed {
		logic [WB_ADDR_WIDTH-1:0] adr;
		logic [WB_DATA_WIDTH-1:0] dat_w;
		logic [WB_SEL_WIDTH-1:0]  sel;
		logic                     we;
		logic                     cyc;
		logic                     stb;
		// Burst tags, carried through as is
		logic [2:0]               cti;
		logic [1:0]               bte;
	} wb_req_t;

	// Slave to master signals
	typedef struct packed {
		logic [WB_DATA_WIDTH-1:0] dat_r;
		logic                     ack;
		logic                     err;
	} wb_rsp_t;

endpackage

/* verilog/wb_ic_rsp_mux.sv */
`timescale 1ns/1ps

// Response mux
// Picks the reply of the latched target and hands it to the master
// No registers here, zero cycles from slave to master
module wb_ic_rsp_mux import wb_ic_pkg::*; (
	// Replies from the four slaves
	input  wb_rsp_t   s_rsp_i [N_SLAVES],

	// Reply from the decode-fail target
	input  wb_rsp_t   err_rsp_i,

	// Latched target from the decoder
	input  slave_id_t sel_id_i,
	input  logic      busy_i,

	// Reply to the master
	output wb_rsp_t   m_rsp_o,

	// Transfer ends on this cycle
	output logic      done_o
);

	// Chosen reply before it leaves the module
	wb_rsp_t rsp_sel;

	always_comb begin
		// Nothing reaches the master while no target is latched
		rsp_sel = '0;

		if (busy_i) begin
			if (sel_id_i == ERR_TARGET) begin
				rsp_sel = err_rsp_i;
			end else begin
				// Only the latched slave may drive the master
				for (int i = 0; i < N_SLAVES; i++) begin
					if (sel_id_i == slave_id_t'(i)) begin
						rsp_sel = s_rsp_i[i];
					end
				end
			end
		end
	end

	assign m_rsp_o = rsp_sel;

	// Either termination releases the decoder latch
	// err matters here, the decode-fail target never acks
	assign done_o = rsp_sel.ack || rsp_sel.err;

endmodule

/* verilog/wb_ic_top.sv */
`timescale 1ns/1ps

// One Wishbone master to four slaves
// Decode latches the target, the error target catches unmapped
// addresses, the response mux returns the chosen reply
module wb_ic_top import wb_ic_pkg::*; (
	input  logic    clk,
	input  logic    rstn,

	// Master side
	input  wb_req_t m_req_i,
	output wb_rsp_t m_rsp_o,

	// Slave side
	output wb_req_t s_req_o [N_SLAVES],
	input  wb_rsp_t s_rsp_i [N_SLAVES]
);

	// Latched target and its valid flag
	slave_id_t sel_id;
	logic      busy;

	// High while the chosen reply carries ack or err
	logic      done;

	// Request and reply of the decode-fail target
	wb_req_t   err_req;
	wb_rsp_t   err_rsp;

	// Decode stage
	wb_ic_addr_decode u_decode (
		.clk       (clk),
		.rstn      (rstn),
		.m_req_i   (m_req_i),
		.done_i    (done),
		.tgt_req_o (s_req_o),
		.err_req_o (err_req),
		.sel_id_o  (sel_id),
		.busy_o    (busy)
	);

	// Execute stage for addresses outside all windows
	wb_ic_decode_err u_decode_err (
		.clk       (clk),
		.rstn      (rstn),
		.err_req_i (err_req),
		.err_rsp_o (err_rsp)
	);

	// Result stage
	// Purely combinational, so a slave ack reaches the master
	// in the same cycle
	wb_ic_rsp_mux u_rsp_mux (
		.s_rsp_i   (s_rsp_i),
		.err_rsp_i (err_rsp),
		.sel_id_i  (sel_id),
		.busy_i    (busy),
		.m_rsp_o   (m_rsp_o),
		.done_o    (done)
	);

endmodule

/* wb_ic.f */
verilog/wb_ic_pkg.sv
verilog/wb_ic_addr_decode.sv
verilog/wb_ic_decode_err.sv
verilog/wb_ic_rsp_mux.sv
verilog/wb_ic_top.sv
sim/wb_ic_tb_clkgen.sv
sim/wb_ic_tb_slave.sv
sim/wb_ic_tb.sv
